// ==== hw/axi_rd_pkg.sv ====
// AXI read slave shared widths, burst and response codes, sequencer states
`default_nettype none

package axi_rd_pkg;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------
    localparam int ADDR_W  = 16;
    localparam int DATA_W  = 32;
    localparam int ID_W    = 4;
    localparam int LEN_W   = 8;   // ARLEN field
    localparam int SIZE_W  = 3;   // ARSIZE field
    localparam int BURST_W = 2;   // ARBURST field
    localparam int RESP_W  = 2;   // RRESP field

    // log2 of bytes per beat on this bus
    localparam int BUS_BYTES_LOG2 = 2;

    // A change of this bit means a 4 KB page crossing
    localparam int BOUNDARY_BIT = 12;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------
    // WRAP runs like INCR in this slave
    typedef enum logic [BURST_W-1:0] {
        BT_FIXED = 2'd0,
        BT_INCR  = 2'd1,
        BT_WRAP  = 2'd2,
        BT_RSVD  = 2'd3
    } burst_e;

    // Only OKAY and SLVERR are ever returned
    typedef enum logic [RESP_W-1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } resp_e;

    // Beat sequencer phases
    typedef enum logic [1:0] {
        BP_IDLE,
        BP_FIRST,   // first beat on the raw start address
        BP_BURST    // remaining beats on aligned address plus increment
    } burst_phase_e;

endpackage

`default_nettype wire

// ==== hw/axi_rd_fifo.sv ====
// Synchronous FIFO with full, almost-full and empty flags
`default_nettype none

module axi_rd_fifo #(
    parameter int WIDTH       = 8,
    parameter int DEPTH       = 4,
    parameter int AFULL_LEVEL = DEPTH
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              push,
    input  wire              pop,
    input  wire [WIDTH-1:0]  din,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             afull,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Pointer step with wrap at DEPTH, so any depth works
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    // Overflow and underflow requests are ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // Head entry shows without a read cycle
    assign dout = mem[rd_ptr];

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // Flags follow the registered count
    assign full  = (count == CNT_W'(DEPTH));
    assign afull = (count >= CNT_W'(AFULL_LEVEL));
    assign empty = (count == '0);

endmodule

`default_nettype wire

// ==== hw/axi_rd_decode.sv ====
// Request register fed by the address queue with size error, alignment and increment
`default_nettype none

module axi_rd_decode (
    input  wire                             clk,
    input  wire                             rst_n,
    // Address queue head
    input  wire                             q_empty,
    output logic                            q_pop,
    input  wire [axi_rd_pkg::ID_W-1:0]      q_id,
    input  wire [axi_rd_pkg::ADDR_W-1:0]    q_addr,
    input  wire [axi_rd_pkg::LEN_W-1:0]     q_len,
    input  wire [axi_rd_pkg::SIZE_W-1:0]    q_size,
    input  wire [axi_rd_pkg::BURST_W-1:0]   q_burst,
    // Held request towards the sequencer
    output logic                            req_valid,
    output logic [axi_rd_pkg::ID_W-1:0]     req_id,
    output logic [axi_rd_pkg::ADDR_W-1:0]   req_start_addr,
    output logic [axi_rd_pkg::ADDR_W-1:0]   req_aligned_addr,
    output logic [axi_rd_pkg::LEN_W-1:0]    req_len,
    output logic [axi_rd_pkg::ADDR_W-1:0]   req_incr,
    output logic                            req_size_err,
    input  wire                             req_done
);

    import axi_rd_pkg::*;

    logic              size_err;
    logic [SIZE_W-1:0] eff_size;
    logic [ADDR_W-1:0] align_mask;
    logic [ADDR_W-1:0] incr;

    // Take the next request once the register is free or freed this cycle
    assign q_pop = !q_empty && (!req_valid || req_done);

    // --------------------------------------------------
    // Request attributes from the queue head
    // --------------------------------------------------
    assign size_err = (q_size > SIZE_W'(BUS_BYTES_LOG2));

    // Oversized transfers align to the bus width
    assign eff_size   = size_err ? SIZE_W'(BUS_BYTES_LOG2) : q_size;
    assign align_mask = {ADDR_W{1'b1}} << eff_size;

    // No address step for FIXED
    assign incr = (q_burst == BT_FIXED) ? '0 : (ADDR_W'(1) << q_size);

    // Valid flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else if (q_pop) begin
            req_valid <= 1'b1;
        end else if (req_done) begin
            req_valid <= 1'b0;
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (q_pop) begin
            req_id           <= q_id;
            req_start_addr   <= q_addr;
            req_aligned_addr <= q_addr & align_mask;
            req_len          <= q_len;
            req_incr         <= incr;
            req_size_err     <= size_err;
        end
    end

endmodule

`default_nettype wire

// ==== hw/axi_rd_burst_gen.sv ====
// Beat sequencer FSM driving memory read strobes, beat addresses and last flags
`default_nettype none

module axi_rd_burst_gen (
    input  wire                             clk,
    input  wire                             rst_n,
    // Held request
    input  wire                             req_valid,
    input  wire [axi_rd_pkg::ID_W-1:0]      req_id,
    input  wire [axi_rd_pkg::ADDR_W-1:0]    req_start_addr,
    input  wire [axi_rd_pkg::ADDR_W-1:0]    req_aligned_addr,
    input  wire [axi_rd_pkg::LEN_W-1:0]     req_len,
    input  wire [axi_rd_pkg::ADDR_W-1:0]    req_incr,
    input  wire                             req_size_err,
    output logic                            req_done,
    // R buffer fill level
    input  wire                             r_afull,
    // Memory read port
    output logic                            m_re,
    output logic [axi_rd_pkg::ADDR_W-1:0]   m_raddr,
    // Beat tags for the delay line
    output logic [axi_rd_pkg::ID_W-1:0]     beat_id,
    output logic                            beat_err,
    output logic                            beat_last
);

    import axi_rd_pkg::*;

    burst_phase_e      state;
    burst_phase_e      state_nxt;
    logic [LEN_W-1:0]  beat_cnt;
    logic [ADDR_W-1:0] burst_addr;
    logic [ADDR_W-1:0] addr_base;
    logic [ADDR_W-1:0] addr_prev;
    logic [ADDR_W-1:0] addr_sum;
    logic [ADDR_W-1:0] addr_nxt;

    // --------------------------------------------------
    // Next beat address
    // --------------------------------------------------
    // After the first beat the step starts from the aligned address
    assign addr_base = (state == BP_FIRST) ? req_aligned_addr : burst_addr;
    assign addr_prev = (state == BP_FIRST) ? req_start_addr : burst_addr;
    assign addr_sum  = addr_base + req_incr;

    // Hold on the previous beat rather than leave the 4 KB page
    assign addr_nxt = (addr_sum[BOUNDARY_BIT] != req_start_addr[BOUNDARY_BIT]) ?
                      addr_prev : addr_sum;

    // --------------------------------------------------
    // Phase decode
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        m_re      = 1'b0;
        m_raddr   = burst_addr;
        beat_last = 1'b0;
        case (state)
            BP_IDLE: begin
                if (req_valid) begin
                    state_nxt = BP_FIRST;
                end
            end
            BP_FIRST: begin
                // Raw, possibly unaligned, start address
                m_raddr = req_start_addr;
                if (!r_afull) begin
                    m_re      = 1'b1;
                    beat_last = (req_len == '0);
                    state_nxt = beat_last ? BP_IDLE : BP_BURST;
                end
            end
            BP_BURST: begin
                if (!r_afull) begin
                    m_re      = 1'b1;
                    beat_last = (beat_cnt == req_len);
                    if (beat_last) begin
                        state_nxt = BP_IDLE;
                    end
                end
            end
            default: state_nxt = BP_IDLE;
        endcase
    end

    // Last beat frees the request register
    assign req_done = beat_last;

    // Tags ride with every strobe
    assign beat_id  = req_id;
    assign beat_err = req_size_err;

    // --------------------------------------------------
    // State and beat counter
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= BP_IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (m_re) begin
                // Beat 0 is the first beat
                beat_cnt <= (state == BP_FIRST) ? LEN_W'(1) : beat_cnt + LEN_W'(1);
            end
        end
    end

    // Address of the beat after the one just issued
    always_ff @(posedge clk) begin
        if (m_re) begin
            burst_addr <= addr_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/axi_rd_resp_align.sv ====
// Delay line aligning beat ID, response and last to memory latency for the R buffer write
`default_nettype none

module axi_rd_resp_align #(
    parameter int SLV_WS = 2
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  m_re,
    input  wire [axi_rd_pkg::ID_W-1:0]           beat_id,
    input  wire                                  beat_err,
    input  wire                                  beat_last,
    input  wire                                  m_rvalid,
    input  wire [axi_rd_pkg::DATA_W-1:0]         m_rdata,
    output logic                                 r_push,
    output logic [axi_rd_pkg::ID_W+axi_rd_pkg::DATA_W+axi_rd_pkg::RESP_W:0] r_din
);

    import axi_rd_pkg::*;

    localparam int TAG_W = ID_W + RESP_W + 1;

    resp_e            beat_resp;
    logic [TAG_W-1:0] tag_in;
    logic [TAG_W-1:0] tag_out;
    logic             vld_out;

    assign beat_resp = beat_err ? RESP_SLVERR : RESP_OKAY;
    assign tag_in    = {beat_id, beat_resp, beat_last};

    // --------------------------------------------------
    // SLV_WS stages
    // --------------------------------------------------
    if (SLV_WS == 0) begin : g_bypass
        assign tag_out = tag_in;
        assign vld_out = m_re;
    end else begin : g_delay
        logic [TAG_W-1:0]  tag_q [SLV_WS];
        logic [SLV_WS-1:0] vld_q;

        // Slot occupancy
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                vld_q <= '0;
            end else begin
                vld_q[0] <= m_re;
                for (int i = 1; i < SLV_WS; i++) begin
                    vld_q[i] <= vld_q[i-1];
                end
            end
        end

        always_ff @(posedge clk) begin
            tag_q[0] <= tag_in;
            for (int i = 1; i < SLV_WS; i++) begin
                tag_q[i] <= tag_q[i-1];
            end
        end

        assign tag_out = tag_q[SLV_WS-1];
        assign vld_out = vld_q[SLV_WS-1];
    end

    // Entry layout is {id, data, resp, last}
    assign r_push = m_rvalid && vld_out;
    assign r_din  = {tag_out[TAG_W-1 -: ID_W], m_rdata, tag_out[RESP_W:0]};

endmodule

`default_nettype wire

// ==== hw/axi_rd_slave.sv ====
// AXI4 read slave top with address queue, decode, sequencer, delay line and R buffer
`default_nettype none

module axi_rd_slave #(
    parameter int AR_DEPTH = 4,
    parameter int R_DEPTH  = 16,
    parameter int SLV_WS   = 2
) (
    input  wire                             clk,
    input  wire                             rst_n,
    // AR channel
    input  wire [axi_rd_pkg::ID_W-1:0]      ARID,
    input  wire [axi_rd_pkg::ADDR_W-1:0]    ARADDR,
    input  wire [axi_rd_pkg::LEN_W-1:0]     ARLEN,
    input  wire [axi_rd_pkg::SIZE_W-1:0]    ARSIZE,
    input  wire [axi_rd_pkg::BURST_W-1:0]   ARBURST,
    input  wire                             ARVALID,
    output logic                            ARREADY,
    // R channel
    output logic [axi_rd_pkg::ID_W-1:0]     RID,
    output logic [axi_rd_pkg::DATA_W-1:0]   RDATA,
    output logic [axi_rd_pkg::RESP_W-1:0]   RRESP,
    output logic                            RLAST,
    output logic                            RVALID,
    input  wire                             RREADY,
    // Memory read port
    output logic                            m_re,
    output logic [axi_rd_pkg::ADDR_W-1:0]   m_raddr,
    input  wire [axi_rd_pkg::DATA_W-1:0]    m_rdata,
    input  wire                             m_rvalid
);

    import axi_rd_pkg::*;

    localparam int AR_W = ID_W + ADDR_W + LEN_W + SIZE_W + BURST_W;
    localparam int R_W  = ID_W + DATA_W + RESP_W + 1;
    // Room for the beats still inside the memory latency
    localparam int R_AFULL = R_DEPTH - SLV_WS - 2;

    logic              ar_push;
    logic              ar_pop;
    logic              ar_full;
    logic              ar_empty;
    logic [AR_W-1:0]   ar_dout;
    logic [ID_W-1:0]   q_id;
    logic [ADDR_W-1:0] q_addr;
    logic [LEN_W-1:0]  q_len;
    logic [SIZE_W-1:0] q_size;
    logic [BURST_W-1:0] q_burst;
    logic              req_valid;
    logic [ID_W-1:0]   req_id;
    logic [ADDR_W-1:0] req_start_addr;
    logic [ADDR_W-1:0] req_aligned_addr;
    logic [LEN_W-1:0]  req_len;
    logic [ADDR_W-1:0] req_incr;
    logic              req_size_err;
    logic              req_done;
    logic [ID_W-1:0]   beat_id;
    logic              beat_err;
    logic              beat_last;
    logic              r_push;
    logic              r_pop;
    logic              r_afull;
    logic              r_empty;
    logic [R_W-1:0]    r_din;
    logic [R_W-1:0]    r_dout;

    // --------------------------------------------------
    // AR side
    // --------------------------------------------------
    assign ARREADY = !ar_full;
    assign ar_push = ARVALID && ARREADY;
    assign {q_id, q_addr, q_len, q_size, q_burst} = ar_dout;

    axi_rd_fifo #(
        .WIDTH       (AR_W),
        .DEPTH       (AR_DEPTH),
        .AFULL_LEVEL (AR_DEPTH)
    ) ar_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (ar_push),
        .pop   (ar_pop),
        .din   ({ARID, ARADDR, ARLEN, ARSIZE, ARBURST}),
        .dout  (ar_dout),
        .full  (ar_full),
        .afull (),
        .empty (ar_empty)
    );

    axi_rd_decode u_decode (
        .clk              (clk),
        .rst_n            (rst_n),
        .q_empty          (ar_empty),
        .q_pop            (ar_pop),
        .q_id             (q_id),
        .q_addr           (q_addr),
        .q_len            (q_len),
        .q_size           (q_size),
        .q_burst          (q_burst),
        .req_valid        (req_valid),
        .req_id           (req_id),
        .req_start_addr   (req_start_addr),
        .req_aligned_addr (req_aligned_addr),
        .req_len          (req_len),
        .req_incr         (req_incr),
        .req_size_err     (req_size_err),
        .req_done         (req_done)
    );

    axi_rd_burst_gen u_burst_gen (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_valid        (req_valid),
        .req_id           (req_id),
        .req_start_addr   (req_start_addr),
        .req_aligned_addr (req_aligned_addr),
        .req_len          (req_len),
        .req_incr         (req_incr),
        .req_size_err     (req_size_err),
        .req_done         (req_done),
        .r_afull          (r_afull),
        .m_re             (m_re),
        .m_raddr          (m_raddr),
        .beat_id          (beat_id),
        .beat_err         (beat_err),
        .beat_last        (beat_last)
    );

    // --------------------------------------------------
    // R side
    // --------------------------------------------------
    axi_rd_resp_align #(
        .SLV_WS (SLV_WS)
    ) u_resp_align (
        .clk       (clk),
        .rst_n     (rst_n),
        .m_re      (m_re),
        .beat_id   (beat_id),
        .beat_err  (beat_err),
        .beat_last (beat_last),
        .m_rvalid  (m_rvalid),
        .m_rdata   (m_rdata),
        .r_push    (r_push),
        .r_din     (r_din)
    );

    axi_rd_fifo #(
        .WIDTH       (R_W),
        .DEPTH       (R_DEPTH),
        .AFULL_LEVEL (R_AFULL)
    ) r_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (r_push),
        .pop   (r_pop),
        .din   (r_din),
        .dout  (r_dout),
        .full  (),
        .afull (r_afull),
        .empty (r_empty)
    );

    // Head entry drives the channel
    assign RVALID = !r_empty;
    assign r_pop  = RVALID && RREADY;
    assign {RID, RDATA, RRESP, RLAST} = r_dout;

endmodule

`default_nettype wire

// ==== verif/axi_rd_checker.sv ====
// R channel and memory address checker with expected beats built from the request table
`default_nettype none

module axi_rd_checker #(
    parameter int                      N_REQ     = 1,
    parameter int                      ENT_W     = 36,
    parameter logic [N_REQ*ENT_W-1:0]  REQ_TABLE = '0
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire [axi_rd_pkg::ID_W-1:0]      RID,
    input  wire [axi_rd_pkg::DATA_W-1:0]    RDATA,
    input  wire [axi_rd_pkg::RESP_W-1:0]    RRESP,
    input  wire                             RLAST,
    input  wire                             RVALID,
    input  wire                             RREADY,
    input  wire                             m_re,
    input  wire [axi_rd_pkg::ADDR_W-1:0]    m_raddr,
    output logic [15:0]                     bursts_done,
    output logic [15:0]                     error_count
);

    import axi_rd_pkg::*;

    localparam int MAX_BEATS = N_REQ * 256;

    logic [ID_W-1:0]   exp_id   [MAX_BEATS];
    logic [ADDR_W-1:0] exp_addr [MAX_BEATS];
    logic [DATA_W-1:0] exp_data [MAX_BEATS];
    logic [RESP_W-1:0] exp_resp [MAX_BEATS];
    logic              exp_last [MAX_BEATS];
    int                total;
    int                beat_idx;
    int                addr_idx;
    logic [15:0]       mismatch_count;
    logic [15:0]       missing_count = '0;

    assign error_count = mismatch_count + missing_count;

    function automatic logic [ENT_W-1:0] table_row(input int i);
        return REQ_TABLE[(N_REQ-1-i)*ENT_W +: ENT_W];
    endfunction

    // Memory returns the word address and its inverse
    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] word_addr;
        word_addr = addr & ~(ADDR_W'((1 << BUS_BYTES_LOG2) - 1));
        return {~word_addr, word_addr};
    endfunction

    // --------------------------------------------------
    // Expected beats in issue order
    // --------------------------------------------------
    task automatic build_expected();
        logic [ENT_W-1:0]   row;
        logic [ID_W-1:0]    id;
        logic [ADDR_W-1:0]  addr;
        logic [LEN_W-1:0]   len;
        logic [SIZE_W-1:0]  size;
        logic [BURST_W-1:0] burst;
        logic               err;
        logic [SIZE_W-1:0]  eff_size;
        logic [ADDR_W-1:0]  aligned;
        logic [ADDR_W-1:0]  incr;
        logic [ADDR_W-1:0]  beat_addr;
        logic [ADDR_W-1:0]  next_addr;
        total = 0;
        for (int i = 0; i < N_REQ; i++) begin
            row = table_row(i);
            {id, addr, len, size, burst} = row[ENT_W-1:1];
            err      = (size > SIZE_W'(BUS_BYTES_LOG2));
            eff_size = err ? SIZE_W'(BUS_BYTES_LOG2) : size;
            aligned  = addr & ~((ADDR_W'(1) << eff_size) - ADDR_W'(1));
            incr     = (burst == BT_FIXED) ? '0 : (ADDR_W'(1) << size);
            // Beat 0 on the raw address and later beats in aligned steps
            beat_addr = addr;
            for (int n = 0; n <= int'(len); n++) begin
                if (n > 0) begin
                    next_addr = ((n == 1) ? aligned : beat_addr) + incr;
                    // Stay on the last in-page word at a 4 KB edge
                    if (next_addr[BOUNDARY_BIT] == addr[BOUNDARY_BIT]) begin
                        beat_addr = next_addr;
                    end
                end
                exp_id[total]   = id;
                exp_addr[total] = beat_addr;
                exp_data[total] = expected_word(beat_addr);
                exp_resp[total] = err ? RESP_SLVERR : RESP_OKAY;
                exp_last[total] = (n == int'(len));
                total++;
            end
        end
    endtask

    initial begin
        build_expected();
    end

    function automatic int field_mismatch(input string name, input logic [DATA_W-1:0] expv,
                                          input logic [DATA_W-1:0] got);
        if (expv !== got) begin
            $display("[FAIL] t=%0t %s exp=%h got=%h", $time, name, expv, got);
            return 1;
        end
        return 0;
    endfunction

    // --------------------------------------------------
    // Compare each memory read address and each accepted R beat
    // --------------------------------------------------
    always @(posedge clk or negedge rst_n) begin
        int errs;
        errs = 0;
        if (!rst_n) begin
            beat_idx       <= 0;
            addr_idx       <= 0;
            mismatch_count <= '0;
            bursts_done    <= '0;
        end else begin
            // Beat addresses leave in the same order as the R beats
            if (m_re) begin
                if (addr_idx >= total) begin
                    $display("extra memory read at time %0t beyond %0d expected", $time, total);
                    errs++;
                end else begin
                    errs += field_mismatch("m_raddr", DATA_W'(exp_addr[addr_idx]),
                                           DATA_W'(m_raddr));
                end
                addr_idx <= addr_idx + 1;
            end
            if (RVALID && RREADY) begin
                if (beat_idx >= total) begin
                    $display("extra R beat at time %0t beyond %0d expected", $time, total);
                    errs++;
                end else begin
                    errs += field_mismatch("RID", DATA_W'(exp_id[beat_idx]), DATA_W'(RID));
                    errs += field_mismatch("RDATA", exp_data[beat_idx], RDATA);
                    errs += field_mismatch("RRESP", DATA_W'(exp_resp[beat_idx]), DATA_W'(RRESP));
                    errs += field_mismatch("RLAST", DATA_W'(exp_last[beat_idx]), DATA_W'(RLAST));
                end
                beat_idx <= beat_idx + 1;
                if (RLAST) begin
                    bursts_done <= bursts_done + 16'd1;
                end
            end
            mismatch_count <= mismatch_count + 16'(errs);
        end
    end

    // Called once all requests are done
    task automatic check_complete();
        if (beat_idx != total) begin
            $display("%0d R beats arrived where %0d were expected", beat_idx, total);
            missing_count = missing_count + 16'd1;
        end
    endtask

endmodule

`default_nettype wire

// ==== verif/axi_rd_slave_tb.sv ====
// Testbench top for the AXI read slave with clock, reset, memory model, request table, AR/R drivers
`default_nettype none

module axi_rd_slave_tb;

    import axi_rd_pkg::*;

    localparam int AR_DEPTH   = 4;
    localparam int R_DEPTH    = 16;
    localparam int SLV_WS     = 2;
    localparam int DRIVE_DLY  = 2;
    localparam int AR_TIMEOUT = 200;
    localparam int R_TIMEOUT  = 2000;

    // --------------------------------------------------
    // Request table
    // --------------------------------------------------
    // Each row holds id, addr, len, size, burst and a flag to wait for completion
    localparam int N_REQ = 13;
    localparam int ENT_W = ID_W + ADDR_W + LEN_W + SIZE_W + BURST_W + 1;
    localparam logic [N_REQ*ENT_W-1:0] REQ_TABLE = {
        {4'd1,  16'h0100, 8'd0,  3'd2, BT_INCR,  1'b1},  // aligned single beat
        {4'd2,  16'h0203, 8'd5,  3'd1, BT_INCR,  1'b1},  // unaligned halfword burst
        {4'd3,  16'h0312, 8'd3,  3'd2, BT_INCR,  1'b1},  // unaligned word burst
        {4'd4,  16'h0440, 8'd3,  3'd2, BT_FIXED, 1'b1},
        {4'd5,  16'h0500, 8'd2,  3'd3, BT_INCR,  1'b1},  // size above bus width
        {4'd6,  16'h0ff0, 8'd7,  3'd2, BT_INCR,  1'b1},  // runs into 0x1000
        // Back-to-back requests fill the queue under back-pressure
        {4'd7,  16'h1000, 8'd15, 3'd2, BT_INCR,  1'b0},
        {4'd8,  16'h2002, 8'd9,  3'd1, BT_INCR,  1'b0},
        {4'd9,  16'h3004, 8'd4,  3'd2, BT_FIXED, 1'b0},
        {4'd10, 16'h4001, 8'd11, 3'd0, BT_INCR,  1'b0},
        {4'd11, 16'h5fe8, 8'd15, 3'd2, BT_INCR,  1'b0},
        {4'd12, 16'h6100, 8'd0,  3'd2, BT_INCR,  1'b0},
        {4'd13, 16'h7010, 8'd3,  3'd4, BT_INCR,  1'b1}
    };

    logic                clk;
    logic                rst_n;
    logic [ID_W-1:0]     ARID;
    logic [ADDR_W-1:0]   ARADDR;
    logic [LEN_W-1:0]    ARLEN;
    logic [SIZE_W-1:0]   ARSIZE;
    logic [BURST_W-1:0]  ARBURST;
    logic                ARVALID;
    logic                ARREADY;
    logic [ID_W-1:0]     RID;
    logic [DATA_W-1:0]   RDATA;
    logic [RESP_W-1:0]   RRESP;
    logic                RLAST;
    logic                RVALID;
    logic                RREADY = 1'b0;
    logic                m_re;
    logic [ADDR_W-1:0]   m_raddr;
    logic [DATA_W-1:0]   m_rdata = '0;
    logic                m_rvalid = 1'b0;
    logic [15:0]         chk_errors;
    logic [15:0]         bursts_done;
    logic [31:0]         lfsr = 32'h1d54486b;
    logic [SLV_WS-1:0]   re_pipe = '0;
    logic [ADDR_W-1:0]   addr_pipe [SLV_WS];
    int                  timeouts = 0;
    logic                aborted = 1'b0;

    axi_rd_slave #(
        .AR_DEPTH (AR_DEPTH),
        .R_DEPTH  (R_DEPTH),
        .SLV_WS   (SLV_WS)
    ) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .ARID     (ARID),
        .ARADDR   (ARADDR),
        .ARLEN    (ARLEN),
        .ARSIZE   (ARSIZE),
        .ARBURST  (ARBURST),
        .ARVALID  (ARVALID),
        .ARREADY  (ARREADY),
        .RID      (RID),
        .RDATA    (RDATA),
        .RRESP    (RRESP),
        .RLAST    (RLAST),
        .RVALID   (RVALID),
        .RREADY   (RREADY),
        .m_re     (m_re),
        .m_raddr  (m_raddr),
        .m_rdata  (m_rdata),
        .m_rvalid (m_rvalid)
    );

    axi_rd_checker #(
        .N_REQ     (N_REQ),
        .ENT_W     (ENT_W),
        .REQ_TABLE (REQ_TABLE)
    ) chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .RID         (RID),
        .RDATA       (RDATA),
        .RRESP       (RRESP),
        .RLAST       (RLAST),
        .RVALID      (RVALID),
        .RREADY      (RREADY),
        .m_re        (m_re),
        .m_raddr     (m_raddr),
        .bursts_done (bursts_done),
        .error_count (chk_errors)
    );

    always #10 clk = ~clk;

    // First table row sits in the top bits
    function automatic logic [ENT_W-1:0] table_row(input int i);
        return REQ_TABLE[(N_REQ-1-i)*ENT_W +: ENT_W];
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Word address in the low half and its inverse in the high half
    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] word_addr;
        word_addr = addr & ~(ADDR_W'((1 << BUS_BYTES_LOG2) - 1));
        return {~word_addr, word_addr};
    endfunction

    // --------------------------------------------------
    // Memory model and R back-pressure
    // --------------------------------------------------
    // Answers every m_re after SLV_WS edges
    always @(posedge clk) begin
        if (!rst_n) begin
            re_pipe = '0;
        end else begin
            for (int i = SLV_WS - 1; i > 0; i--) begin
                re_pipe[i]   = re_pipe[i-1];
                addr_pipe[i] = addr_pipe[i-1];
            end
            re_pipe[0]   = m_re;
            addr_pipe[0] = m_raddr;
        end
        #DRIVE_DLY;
        m_rvalid = re_pipe[SLV_WS-1];
        m_rdata  = re_pipe[SLV_WS-1] ? mem_word(addr_pipe[SLV_WS-1]) : '0;
    end

    // One LFSR bit per cycle gives ready about half the time
    always @(posedge clk) begin
        #DRIVE_DLY;
        lfsr   = next_lfsr(lfsr);
        RREADY = rst_n && lfsr[0];
    end

    // --------------------------------------------------
    // AR driver and completion wait
    // --------------------------------------------------
    task automatic send_request(input logic [ENT_W-1:0] row);
        int   cycles;
        logic accepted;
        cycles   = 0;
        accepted = 1'b0;
        {ARID, ARADDR, ARLEN, ARSIZE, ARBURST} = row[ENT_W-1:1];
        ARVALID = 1'b1;
        while (!accepted && cycles < AR_TIMEOUT) begin
            @(posedge clk);
            accepted = ARREADY;
            cycles++;
            #DRIVE_DLY;
        end
        ARVALID = 1'b0;
        if (!accepted) begin
            $display("timeout: ARREADY stayed low for request id %0d", row[ENT_W-1 -: ID_W]);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    // Wait for RLAST of every burst issued so far
    task automatic wait_bursts(input int target);
        int cycles;
        cycles = 0;
        while (int'(bursts_done) < target && cycles < R_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            #DRIVE_DLY;
        end
        if (int'(bursts_done) < target) begin
            $display("timeout: %0d of %0d bursts ended with RLAST", bursts_done, target);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    initial begin
        logic [ENT_W-1:0] row;
        int               issued;
        issued  = 0;
        clk     = 1'b0;
        rst_n   = 1'b0;
        ARID    = '0;
        ARADDR  = '0;
        ARLEN   = '0;
        ARSIZE  = '0;
        ARBURST = '0;
        ARVALID = 1'b0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        for (int i = 0; i < N_REQ; i++) begin
            row = table_row(i);
            if (!aborted) begin
                send_request(row);
            end
            if (!aborted) begin
                issued++;
                if (row[0]) begin
                    wait_bursts(issued);
                end
            end
        end

        if (!aborted) begin
            chk.check_complete();
        end
        // Error count settles on the next edge
        @(posedge clk);
        #DRIVE_DLY;
        $display("errors: checker %0d, timeouts %0d", chk_errors, timeouts);
        if (chk_errors == 16'd0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== axi_rd_slave.f ====
hw/axi_rd_pkg.sv
hw/axi_rd_fifo.sv
hw/axi_rd_decode.sv
hw/axi_rd_burst_gen.sv
hw/axi_rd_resp_align.sv
hw/axi_rd_slave.sv
verif/axi_rd_checker.sv
verif/axi_rd_slave_tb.sv

// ==== Makefile ====
# Verilator simulation of the AXI read slave testbench

VERILATOR ?= verilator
TOP       ?= axi_rd_slave_tb
FILELIST  ?= axi_rd_slave.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -qF '** FAIL **' $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
